//--- rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // ==============================
  // Bus widths
  // ==============================
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = 4;

  // ==============================
  // Memory map
  // ==============================
  localparam logic [ADDR_WIDTH-1:0] ROM_BASE = 32'h0000_0000;
  localparam logic [ADDR_WIDTH-1:0] ROM_MASK = 32'h0000_00FF;
  localparam logic [ADDR_WIDTH-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [ADDR_WIDTH-1:0] CLINT_MASK = 32'h0000_FFFF;
  localparam logic [ADDR_WIDTH-1:0] RAM_BASE = 32'h1000_0000;
  localparam logic [ADDR_WIDTH-1:0] RAM_MASK = 32'h0000_03FF;

  // Word counts of the two memories.
  localparam int ROM_WORDS = 64;
  localparam int ROM_INDEX_WIDTH = $clog2(ROM_WORDS);
  localparam int RAM_WORDS = 256;
  localparam int RAM_INDEX_WIDTH = $clog2(RAM_WORDS);

  // ==============================
  // Timer registers
  // ==============================
  localparam logic [ADDR_WIDTH-1:0] CLINT_MSIP = 32'h0000_0000;
  localparam logic [ADDR_WIDTH-1:0] CLINT_MTIMECMP_LO = 32'h0000_4000;
  localparam logic [ADDR_WIDTH-1:0] CLINT_MTIMECMP_HI = 32'h0000_4004;
  localparam logic [ADDR_WIDTH-1:0] CLINT_MTIME_LO = 32'h0000_BFF8;
  localparam logic [ADDR_WIDTH-1:0] CLINT_MTIME_HI = 32'h0000_BFFC;

  localparam int TICK_DIVIDER = 4;
  localparam int TICK_WIDTH = $clog2(TICK_DIVIDER);

  // Target of the outstanding request.
  typedef enum logic [1:0] {
    TARGET_NONE,
    TARGET_ROM,
    TARGET_RAM,
    TARGET_CLINT
  } target_e;

  // Boot image rule.
  function automatic logic [DATA_WIDTH-1:0] rom_word(input int unsigned index);
    return 32'hB007_0000 + DATA_WIDTH'(index);
  endfunction

endpackage

`default_nettype wire

//--- rtl/peripheral_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module peripheral_decoder (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              mem_valid,
  input  logic [bus_pkg::ADDR_WIDTH-1:0]    mem_addr,
  input  logic [bus_pkg::DATA_WIDTH-1:0]    mem_wdata,
  input  logic [bus_pkg::STRB_WIDTH-1:0]    mem_wstrb,
  output logic                              mem_ready,
  output logic [bus_pkg::DATA_WIDTH-1:0]    mem_rdata,
  output logic                              mem_error,
  output logic                              rom_valid,
  output logic [bus_pkg::ADDR_WIDTH-1:0]    rom_addr,
  output logic [bus_pkg::DATA_WIDTH-1:0]    rom_wdata,
  output logic [bus_pkg::STRB_WIDTH-1:0]    rom_wstrb,
  input  logic                              rom_ready,
  input  logic [bus_pkg::DATA_WIDTH-1:0]    rom_rdata,
  input  logic                              rom_error,
  output logic                              ram_valid,
  output logic [bus_pkg::ADDR_WIDTH-1:0]    ram_addr,
  output logic [bus_pkg::DATA_WIDTH-1:0]    ram_wdata,
  output logic [bus_pkg::STRB_WIDTH-1:0]    ram_wstrb,
  input  logic                              ram_ready,
  input  logic [bus_pkg::DATA_WIDTH-1:0]    ram_rdata,
  input  logic                              ram_error,
  output logic                              clint_valid,
  output logic [bus_pkg::ADDR_WIDTH-1:0]    clint_addr,
  output logic [bus_pkg::DATA_WIDTH-1:0]    clint_wdata,
  output logic [bus_pkg::STRB_WIDTH-1:0]    clint_wstrb,
  input  logic                              clint_ready,
  input  logic [bus_pkg::DATA_WIDTH-1:0]    clint_rdata,
  input  logic                              clint_error
);

  logic rom_hit;
  logic ram_hit;
  logic clint_hit;
  bus_pkg::target_e target;
  bus_pkg::target_e target_q;
  logic error_q;

  // ==============================
  // Request side
  // ==============================
  assign rom_hit = (mem_addr & ~bus_pkg::ROM_MASK) == bus_pkg::ROM_BASE;
  assign ram_hit = (mem_addr & ~bus_pkg::RAM_MASK) == bus_pkg::RAM_BASE;
  assign clint_hit = (mem_addr & ~bus_pkg::CLINT_MASK) == bus_pkg::CLINT_BASE;

  assign rom_valid = mem_valid & rom_hit;
  assign rom_addr = mem_addr - bus_pkg::ROM_BASE;
  assign rom_wdata = mem_wdata;
  assign rom_wstrb = mem_wstrb;

  assign ram_valid = mem_valid & ram_hit;
  assign ram_addr = mem_addr - bus_pkg::RAM_BASE;
  assign ram_wdata = mem_wdata;
  assign ram_wstrb = mem_wstrb;

  assign clint_valid = mem_valid & clint_hit;
  assign clint_addr = mem_addr - bus_pkg::CLINT_BASE;
  assign clint_wdata = mem_wdata;
  assign clint_wstrb = mem_wstrb;

  always_comb begin
    if (rom_hit) begin
      target = bus_pkg::TARGET_ROM;
    end else if (ram_hit) begin
      target = bus_pkg::TARGET_RAM;
    end else if (clint_hit) begin
      target = bus_pkg::TARGET_CLINT;
    end else begin
      target = bus_pkg::TARGET_NONE;
    end
  end

  // Selected target and the error responder.
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      target_q <= bus_pkg::TARGET_NONE;
      error_q <= 1'b0;
    end else begin
      target_q <= mem_valid ? target : bus_pkg::TARGET_NONE;
      error_q <= mem_valid & (target == bus_pkg::TARGET_NONE);
    end
  end

  // ==============================
  // Response side
  // ==============================
  always_comb begin
    case (target_q)
      bus_pkg::TARGET_ROM: begin
        mem_ready = rom_ready;
        mem_rdata = rom_rdata;
        mem_error = rom_error;
      end
      bus_pkg::TARGET_RAM: begin
        mem_ready = ram_ready;
        mem_rdata = ram_rdata;
        mem_error = ram_error;
      end
      bus_pkg::TARGET_CLINT: begin
        mem_ready = clint_ready;
        mem_rdata = clint_rdata;
        mem_error = clint_error;
      end
      default: begin
        mem_ready = error_q;
        mem_rdata = '0;
        mem_error = error_q;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              rom_valid,
  input  logic [bus_pkg::ADDR_WIDTH-1:0]    rom_addr,
  input  logic [bus_pkg::STRB_WIDTH-1:0]    rom_wstrb,
  output logic                              rom_ready,
  output logic [bus_pkg::DATA_WIDTH-1:0]    rom_rdata,
  output logic                              rom_error
);

  logic [bus_pkg::DATA_WIDTH-1:0] image [bus_pkg::ROM_WORDS];
  logic [bus_pkg::ROM_INDEX_WIDTH-1:0] index;
  logic write;

  // Image built from the package rule.
  for (genvar i = 0; i < bus_pkg::ROM_WORDS; i++) begin : g_image
    assign image[i] = bus_pkg::rom_word(i);
  end

  assign index = rom_addr[bus_pkg::ROM_INDEX_WIDTH+1:2];
  assign write = |rom_wstrb;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      rom_ready <= 1'b0;
      rom_error <= 1'b0;
    end else begin
      rom_ready <= rom_valid;
      rom_error <= rom_valid & write;
    end
  end

  // Writes are refused with zero data.
  always_ff @(posedge clock) begin
    if (rom_valid) begin
      rom_rdata <= write ? '0 : image[index];
    end
  end

endmodule

`default_nettype wire

//--- rtl/scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              ram_valid,
  input  logic [bus_pkg::ADDR_WIDTH-1:0]    ram_addr,
  input  logic [bus_pkg::DATA_WIDTH-1:0]    ram_wdata,
  input  logic [bus_pkg::STRB_WIDTH-1:0]    ram_wstrb,
  output logic                              ram_ready,
  output logic [bus_pkg::DATA_WIDTH-1:0]    ram_rdata,
  output logic                              ram_error
);

  logic [bus_pkg::DATA_WIDTH-1:0] memory [bus_pkg::RAM_WORDS];
  logic [bus_pkg::RAM_INDEX_WIDTH-1:0] index;

  assign index = ram_addr[bus_pkg::RAM_INDEX_WIDTH+1:2];

  // Every access succeeds.
  assign ram_error = 1'b0;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      ram_ready <= 1'b0;
    end else begin
      ram_ready <= ram_valid;
    end
  end

  // ==============================
  // Storage
  // ==============================
  always_ff @(posedge clock) begin
    if (ram_valid) begin
      for (int b = 0; b < bus_pkg::STRB_WIDTH; b++) begin
        if (ram_wstrb[b]) begin
          memory[index][8*b +: 8] <= ram_wdata[8*b +: 8];
        end
      end
      ram_rdata <= memory[index];
    end
  end

endmodule

`default_nettype wire

//--- rtl/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              clint_valid,
  input  logic [bus_pkg::ADDR_WIDTH-1:0]    clint_addr,
  input  logic [bus_pkg::DATA_WIDTH-1:0]    clint_wdata,
  input  logic [bus_pkg::STRB_WIDTH-1:0]    clint_wstrb,
  output logic                              clint_ready,
  output logic [bus_pkg::DATA_WIDTH-1:0]    clint_rdata,
  output logic                              clint_error,
  output logic                              msip,
  output logic                              mtip
);

  logic [bus_pkg::TICK_WIDTH-1:0] prescale;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [63:0] mtime_next;
  logic [63:0] mtimecmp_next;
  logic msip_next;
  logic tick;
  logic write;
  logic hit;
  logic [bus_pkg::DATA_WIDTH-1:0] read_value;

  // Byte merge of a write into one 32-bit half.
  function automatic logic [31:0] merge(input logic [31:0] old_value,
                                        input logic [31:0] new_value,
                                        input logic [3:0] strobe);
    logic [31:0] result;
    result = old_value;
    for (int b = 0; b < 4; b++) begin
      if (strobe[b]) begin
        result[8*b +: 8] = new_value[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign tick = prescale == bus_pkg::TICK_WIDTH'(bus_pkg::TICK_DIVIDER - 1);
  assign write = clint_valid & |clint_wstrb;

  // ==============================
  // Register access
  // ==============================
  always_comb begin
    mtime_next = mtime + 64'(tick);
    mtimecmp_next = mtimecmp;
    msip_next = msip;
    hit = 1'b1;
    read_value = '0;
    case (clint_addr)
      bus_pkg::CLINT_MSIP: begin
        read_value = {31'b0, msip};
        if (write && clint_wstrb[0]) begin
          msip_next = clint_wdata[0];
        end
      end
      bus_pkg::CLINT_MTIMECMP_LO: begin
        read_value = mtimecmp[31:0];
        if (write) begin
          mtimecmp_next[31:0] = merge(mtimecmp[31:0], clint_wdata, clint_wstrb);
        end
      end
      bus_pkg::CLINT_MTIMECMP_HI: begin
        read_value = mtimecmp[63:32];
        if (write) begin
          mtimecmp_next[63:32] = merge(mtimecmp[63:32], clint_wdata, clint_wstrb);
        end
      end
      bus_pkg::CLINT_MTIME_LO: begin
        read_value = mtime[31:0];
        if (write) begin
          mtime_next[31:0] = merge(mtime[31:0], clint_wdata, clint_wstrb);
        end
      end
      bus_pkg::CLINT_MTIME_HI: begin
        read_value = mtime[63:32];
        if (write) begin
          mtime_next[63:32] = merge(mtime[63:32], clint_wdata, clint_wstrb);
        end
      end
      default: hit = 1'b0;
    endcase
  end

  // Timer state and response.
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      prescale <= '0;
      mtime <= '0;
      mtimecmp <= '1;
      msip <= 1'b0;
      mtip <= 1'b0;
      clint_ready <= 1'b0;
      clint_error <= 1'b0;
    end else begin
      prescale <= tick ? '0 : prescale + 1'b1;
      mtime <= mtime_next;
      mtimecmp <= mtimecmp_next;
      msip <= msip_next;
      mtip <= mtime >= mtimecmp;
      clint_ready <= clint_valid;
      clint_error <= clint_valid & ~hit;
    end
  end

  always_ff @(posedge clock) begin
    if (clint_valid) begin
      clint_rdata <= read_value;
    end
  end

endmodule

`default_nettype wire

//--- rtl/periph_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              mem_valid,
  input  logic [bus_pkg::ADDR_WIDTH-1:0]    mem_addr,
  input  logic [bus_pkg::DATA_WIDTH-1:0]    mem_wdata,
  input  logic [bus_pkg::STRB_WIDTH-1:0]    mem_wstrb,
  output logic                              mem_ready,
  output logic [bus_pkg::DATA_WIDTH-1:0]    mem_rdata,
  output logic                              mem_error,
  output logic                              msip,
  output logic                              mtip
);

  logic rom_valid;
  logic [bus_pkg::ADDR_WIDTH-1:0] rom_addr;
  logic [bus_pkg::STRB_WIDTH-1:0] rom_wstrb;
  logic rom_ready;
  logic [bus_pkg::DATA_WIDTH-1:0] rom_rdata;
  logic rom_error;

  logic ram_valid;
  logic [bus_pkg::ADDR_WIDTH-1:0] ram_addr;
  logic [bus_pkg::DATA_WIDTH-1:0] ram_wdata;
  logic [bus_pkg::STRB_WIDTH-1:0] ram_wstrb;
  logic ram_ready;
  logic [bus_pkg::DATA_WIDTH-1:0] ram_rdata;
  logic ram_error;

  logic clint_valid;
  logic [bus_pkg::ADDR_WIDTH-1:0] clint_addr;
  logic [bus_pkg::DATA_WIDTH-1:0] clint_wdata;
  logic [bus_pkg::STRB_WIDTH-1:0] clint_wstrb;
  logic clint_ready;
  logic [bus_pkg::DATA_WIDTH-1:0] clint_rdata;
  logic clint_error;

  // ROM takes no write data.
  peripheral_decoder peripheral_decoder_i (
    .clock       (clock),
    .reset       (reset),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .mem_error   (mem_error),
    .rom_valid   (rom_valid),
    .rom_addr    (rom_addr),
    .rom_wdata   (),
    .rom_wstrb   (rom_wstrb),
    .rom_ready   (rom_ready),
    .rom_rdata   (rom_rdata),
    .rom_error   (rom_error),
    .ram_valid   (ram_valid),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .ram_wstrb   (ram_wstrb),
    .ram_ready   (ram_ready),
    .ram_rdata   (ram_rdata),
    .ram_error   (ram_error),
    .clint_valid (clint_valid),
    .clint_addr  (clint_addr),
    .clint_wdata (clint_wdata),
    .clint_wstrb (clint_wstrb),
    .clint_ready (clint_ready),
    .clint_rdata (clint_rdata),
    .clint_error (clint_error)
  );

  boot_rom boot_rom_i (
    .clock     (clock),
    .reset     (reset),
    .rom_valid (rom_valid),
    .rom_addr  (rom_addr),
    .rom_wstrb (rom_wstrb),
    .rom_ready (rom_ready),
    .rom_rdata (rom_rdata),
    .rom_error (rom_error)
  );

  scratch_ram scratch_ram_i (
    .clock     (clock),
    .reset     (reset),
    .ram_valid (ram_valid),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_wstrb (ram_wstrb),
    .ram_ready (ram_ready),
    .ram_rdata (ram_rdata),
    .ram_error (ram_error)
  );

  clint_timer clint_timer_i (
    .clock       (clock),
    .reset       (reset),
    .clint_valid (clint_valid),
    .clint_addr  (clint_addr),
    .clint_wdata (clint_wdata),
    .clint_wstrb (clint_wstrb),
    .clint_ready (clint_ready),
    .clint_rdata (clint_rdata),
    .clint_error (clint_error),
    .msip        (msip),
    .mtip        (mtip)
  );

endmodule

`default_nettype wire

//--- verification/periph_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem_tb;

  localparam int CLOCK_PERIOD = 10;
  localparam int RESET_CYCLES = 8;
  localparam int GAP_CYCLES = 40;
  // About 700 cycles of tests, with a wide margin.
  localparam int WATCHDOG_CYCLES = 2000;

  logic clock;
  logic reset;
  logic mem_valid;
  logic [bus_pkg::ADDR_WIDTH-1:0] mem_addr;
  logic [bus_pkg::DATA_WIDTH-1:0] mem_wdata;
  logic [bus_pkg::STRB_WIDTH-1:0] mem_wstrb;
  logic mem_ready;
  logic [bus_pkg::DATA_WIDTH-1:0] mem_rdata;
  logic mem_error;
  logic msip;
  logic mtip;

  int handshake_errors = 0;
  int data_errors = 0;
  logic [31:0] last_rdata;
  logic last_error;
  logic [31:0] ram_shadow [bus_pkg::RAM_WORDS];
  int unsigned ram_used [$];

  periph_subsystem periph_subsystem_i (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .mem_error (mem_error),
    .msip      (msip),
    .mtip      (mtip)
  );

  initial clock = 1'b0;
  always #(CLOCK_PERIOD / 2) clock = ~clock;

  // ==============================
  // Handshake checks
  // ==============================
  request_answered: assert property (@(posedge clock) disable iff (reset == 1'b0)
      mem_valid |=> mem_ready)
    else begin
      handshake_errors++;
      $display("FAIL %0t: request not answered in the next cycle", $time);
    end

  no_spurious_ready: assert property (@(posedge clock) disable iff (reset == 1'b0)
      mem_ready |-> $past(mem_valid))
    else begin
      handshake_errors++;
      $display("FAIL %0t: mem_ready without a request", $time);
    end

  reset_values: assert property (@(posedge clock)
      $rose(reset) |-> (!mem_ready && !mem_error && !msip && !mtip))
    else begin
      handshake_errors++;
      $display("FAIL %0t: outputs not low after reset", $time);
    end

  // Byte-lane merge of a strobed write.
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strobe);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strobe[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic bus_pkg::target_e window_of(input logic [31:0] addr);
    if ((addr & ~bus_pkg::ROM_MASK) == bus_pkg::ROM_BASE) begin
      return bus_pkg::TARGET_ROM;
    end else if ((addr & ~bus_pkg::RAM_MASK) == bus_pkg::RAM_BASE) begin
      return bus_pkg::TARGET_RAM;
    end else if ((addr & ~bus_pkg::CLINT_MASK) == bus_pkg::CLINT_BASE) begin
      return bus_pkg::TARGET_CLINT;
    end
    return bus_pkg::TARGET_NONE;
  endfunction

  task automatic expect_true(input logic condition, input string what);
    assert (condition === 1'b1) else begin
      data_errors++;
      $display("FAIL %0t: %s", $time, what);
    end
  endtask

  // One request pulse, then wait for the response cycle.
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
    @(posedge clock);
    #1;
    mem_valid = 1'b1;
    mem_addr = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    @(posedge clock);
    #1;
    mem_valid = 1'b0;
    mem_wstrb = '0;
    while (mem_ready !== 1'b1) begin
      @(posedge clock);
      #1;
    end
    last_rdata = mem_rdata;
    last_error = mem_error;
  endtask

  // Access with the expected response taken from the memory map.
  task automatic check_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, input string what);
    bus_pkg::target_e target;
    logic [31:0] exp_rdata;
    logic exp_error;
    logic compare_data;
    int unsigned index;
    target = window_of(addr);
    exp_rdata = '0;
    exp_error = 1'b1;
    compare_data = 1'b1;
    case (target)
      bus_pkg::TARGET_ROM: begin
        index = (addr - bus_pkg::ROM_BASE) >> 2;
        exp_error = |wstrb;
        if (wstrb == '0) begin
          exp_rdata = 32'hB007_0000 + index;
        end
      end
      bus_pkg::TARGET_RAM: begin
        index = (addr - bus_pkg::RAM_BASE) >> 2;
        exp_error = 1'b0;
        exp_rdata = ram_shadow[index];
        compare_data = (wstrb == '0);
        ram_shadow[index] = merge_bytes(ram_shadow[index], wdata, wstrb);
      end
      // Unmapped windows and timer holes.
      default: ;
    endcase
    bus_access(addr, wdata, wstrb);
    expect_true(last_error === exp_error,
                $sformatf("%s at %h: error %b, expected %b", what, addr, last_error, exp_error));
    if (compare_data) begin
      expect_true(last_rdata === exp_rdata,
                  $sformatf("%s at %h: data %h, expected %h", what, addr, last_rdata, exp_rdata));
    end
  endtask

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    int unsigned index;
    int wait_cycles;
    logic [31:0] time_first;
    logic [31:0] time_second;
    logic [31:0] time_high;
    logic [63:0] compare;
    void'($urandom(32'h1b4d_eaf1));
    reset = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b1;

    for (int i = 0; i < bus_pkg::ROM_WORDS; i++) begin
      check_access(bus_pkg::ROM_BASE + 32'(4 * i), '0, '0, "rom read");
    end
    check_access(bus_pkg::ROM_BASE + 32'h10, 32'hDEAD_BEEF, 4'hF, "rom write");

    // Full-word fill first, so the shadow holds known words.
    repeat (16) begin
      index = $urandom % bus_pkg::RAM_WORDS;
      ram_used.push_back(index);
      check_access(bus_pkg::RAM_BASE + index * 4, $urandom, 4'hF, "ram fill");
    end
    repeat (48) begin
      index = ram_used[$urandom % ram_used.size()];
      check_access(bus_pkg::RAM_BASE + index * 4, $urandom, 4'($urandom), "ram write");
      check_access(bus_pkg::RAM_BASE + index * 4, '0, '0, "ram read");
    end

    check_access(32'h3000_0000, '0, '0, "unmapped read");
    check_access(32'h3000_0000, 32'h1234_5678, 4'hF, "unmapped write");
    check_access(32'h1000_0400, '0, '0, "past ram read");
    check_access(32'h1000_0400, 32'h1234_5678, 4'hF, "past ram write");
    check_access(bus_pkg::CLINT_BASE + 32'h8, '0, '0, "timer hole read");
    check_access(bus_pkg::CLINT_BASE + 32'h8, 32'h1, 4'hF, "timer hole write");

    // Software interrupt.
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MSIP, 32'h1, 4'h1);
    expect_true(msip === 1'b1 && last_error === 1'b0, "msip not set by write");
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MSIP, '0, '0);
    expect_true(last_rdata === 32'h1, $sformatf("msip read %h, expected 1", last_rdata));
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MSIP, '0, 4'h1);
    expect_true(msip === 1'b0, "msip not cleared by write");
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MSIP, '0, '0);
    expect_true(last_rdata === 32'h0, $sformatf("msip read %h, expected 0", last_rdata));

    // mtime rate.
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MTIME_LO, '0, '0);
    time_first = last_rdata;
    repeat (GAP_CYCLES) @(posedge clock);
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MTIME_LO, '0, '0);
    time_second = last_rdata;
    expect_true(time_second - time_first >= GAP_CYCLES / bus_pkg::TICK_DIVIDER - 1,
                $sformatf("mtime moved from %0d to %0d", time_first, time_second));

    // Timer interrupt.
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MTIME_HI, '0, '0);
    time_high = last_rdata;
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MTIME_LO, '0, '0);
    compare = {time_high, last_rdata} + 64'd20;
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MTIMECMP_LO, compare[31:0], 4'hF);
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MTIMECMP_HI, compare[63:32], 4'hF);
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MTIMECMP_LO, '0, '0);
    expect_true(last_rdata === compare[31:0], "mtimecmp low half read back wrong");
    expect_true(mtip === 1'b0, "mtip high before mtime reached mtimecmp");
    wait_cycles = 0;
    while (mtip !== 1'b1 && wait_cycles < 100) begin
      @(posedge clock);
      #1;
      wait_cycles++;
    end
    expect_true(mtip === 1'b1, "mtip did not rise within 100 cycles");
    repeat (10) begin
      @(posedge clock);
      #1;
      expect_true(mtip === 1'b1, "mtip dropped while mtime >= mtimecmp");
    end
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MTIMECMP_HI, 32'hFFFF_FFFF, 4'hF);
    expect_true(mtip === 1'b1, "mtip dropped before the compare update");
    @(posedge clock);
    #1;
    expect_true(mtip === 1'b0, "mtip still high after mtimecmp rewrite");
    bus_access(bus_pkg::CLINT_BASE + bus_pkg::CLINT_MTIMECMP_LO, 32'hFFFF_FFFF, 4'hF);

    $display("Errors: %0d handshake, %0d data", handshake_errors, data_errors);
    if (handshake_errors + data_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Errors: %0d handshake, %0d data", handshake_errors, data_errors);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
rtl/bus_pkg.sv
rtl/peripheral_decoder.sv
rtl/boot_rom.sv
rtl/scratch_ram.sv
rtl/clint_timer.sv
rtl/periph_subsystem.sv
verification/periph_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_subsystem_tb \
    --Mdir obj_dir -o periph_sim \
    -f sources.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/periph_sim > "$log" 2>&1; then
  cat "$log"
  echo "Simulation run returned an error status"
  exit 1
fi

cat "$log"

if grep -q "Simulation FAILED" "$log"; then
  echo "Failure found in $log"
  exit 1
fi

exit 0
